// ==== hw/cpuPkg.sv ====
package cpuPkg;

	parameter int WordWidth = 32;
	parameter int RegCount = 16;

	// instruction bits 31..27
	typedef enum logic [4:0] {
		opLd = 5'd0,
		opLdi = 5'd1,
		opSt = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opShr = 5'd5,
		opShl = 5'd6,
		opAnd = 5'd9,
		opOr = 5'd10,
		opAddi = 5'd11,
		opAndi = 5'd12,
		opOri = 5'd13,
		opNeg = 5'd16,
		opNot = 5'd17,
		opBr = 5'd18,
		opNop = 5'd25,
		opHalt = 5'd26
	} opcodeT;

	typedef enum logic [4:0] {
		stReset, stFetch0, stFetch1, stFetch2,
		stAlu3, stAlu4, stAlu5,
		stImm3, stImm4, stImm5,
		stUn3, stUn4,
		stLd3, stLd4, stLd5, stLd6, stLd7,
		stLdi3, stLdi4, stLdi5,
		stSt3, stSt4, stSt5, stSt6,
		stBr3, stBr4, stBr5, stBr6,
		stNop3, stHalt
	} stateT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluShl, aluShr, aluNeg, aluNot, aluIncPass
	} aluOpT;

	typedef enum logic [2:0] {
		busReg, busPc, busZLow, busMdr, busImm
	} busSrcT;

	// every level for one step
	typedef struct packed {
		busSrcT busSrc;
		logic gra;
		logic grb;
		logic grc;
		logic rIn;
		logic rOut;
		logic baOut;
		logic yIn;
		logic zIn;
		logic marIn;
		logic mdrIn;
		logic irIn;
		logic pcIn;
		logic pcInc;
		logic conIn;
		logic memRead;
		logic memWrite;
		aluOpT aluOp;
	} ctrlT;

endpackage

// ==== hw/programCounter.sv ====
`timescale 1ns/10ps

module programCounter (
	input logic Clock,
	input logic Reset,
	input logic Inc,
	input logic Load,
	input logic [cpuPkg::WordWidth-1:0] Bus,
	output logic [cpuPkg::WordWidth-1:0] Pc
);

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			Pc <= '0;
		else if (Load) // branch target over increment
			Pc <= Bus;
		else if (Inc)
			Pc <= Pc + 1;
	end

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/10ps

module registerFile (
	input logic Clock,
	input logic Reset,
	input logic [cpuPkg::WordWidth-1:0] Ir,
	input logic Gra,
	input logic Grb,
	input logic Grc,
	input logic RIn,
	input logic ROut,
	input logic BaOut,
	input logic [cpuPkg::WordWidth-1:0] Bus,
	output logic [cpuPkg::WordWidth-1:0] RegOut
);
	import cpuPkg::*;

	logic [WordWidth-1:0] regs [RegCount];
	logic [$clog2(RegCount)-1:0] sel;

	always_comb begin
		sel = '0;
		if (Gra)
			sel = Ir[26:23]; // ra
		else if (Grb)
			sel = Ir[22:19]; // rb
		else if (Grc)
			sel = Ir[18:15]; // rc
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < RegCount; i++)
				regs[i] <= '0;
		end else if (RIn) begin
			regs[sel] <= Bus;
		end
	end

	// base addressing sees r0 as zero
	assign RegOut = (ROut || (BaOut && sel != '0)) ? regs[sel] : '0;

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu (
	input cpuPkg::aluOpT Op,
	input logic [cpuPkg::WordWidth-1:0] A,
	input logic [cpuPkg::WordWidth-1:0] B,
	output logic [cpuPkg::WordWidth-1:0] Result
);
	import cpuPkg::*;

	logic [4:0] shamt;

	assign shamt = B[4:0];

	always_comb begin
		case (Op)
			aluAdd: Result = A + B;
			aluSub: Result = A - B;
			aluAnd: Result = A & B;
			aluOr: Result = A | B;
			aluShl: Result = A << shamt;
			aluShr: Result = A >> shamt; // logical
			aluNeg: Result = -B; // unary ops take the bus only
			aluNot: Result = ~B;
			aluIncPass: Result = A + B; // address add
			default: Result = '0;
		endcase
	end

endmodule

// ==== hw/dataMemory.sv ====
`timescale 1ns/10ps

module dataMemory #(
	parameter int MemAddrWidth = 9
) (
	input logic Clock,
	input logic Read,
	input logic Write,
	input logic [MemAddrWidth-1:0] Address,
	input logic [cpuPkg::WordWidth-1:0] WriteData,
	output logic [cpuPkg::WordWidth-1:0] ReadData,
	input logic LoadWrite,
	input logic [MemAddrWidth-1:0] LoadAddress,
	input logic [cpuPkg::WordWidth-1:0] LoadData,
	output logic [cpuPkg::WordWidth-1:0] ProbeData
);
	import cpuPkg::*;

	logic [WordWidth-1:0] mem [2**MemAddrWidth];

	always_ff @(posedge Clock) begin
		if (LoadWrite) // external port first
			mem[LoadAddress] <= LoadData;
		else if (Write)
			mem[Address] <= WriteData;
		if (Read)
			ReadData <= mem[Address];
	end

	assign ProbeData = mem[LoadAddress];

endmodule

// ==== hw/dataPath.sv ====
`timescale 1ns/10ps

module dataPath #(
	parameter int MemAddrWidth = 9
) (
	input logic Clock,
	input logic Reset,
	input cpuPkg::ctrlT Ctrl,
	input logic [cpuPkg::WordWidth-1:0] MemData,
	output logic [MemAddrWidth-1:0] MemAddress,
	output logic [cpuPkg::WordWidth-1:0] StoreData,
	output cpuPkg::opcodeT Opcode,
	output logic Con
);
	import cpuPkg::*;

	logic [WordWidth-1:0] bus;
	logic [WordWidth-1:0] pc;
	logic [WordWidth-1:0] regOut;
	logic [WordWidth-1:0] aluResult;
	logic [WordWidth-1:0] y;
	logic [WordWidth-1:0] z;
	logic [WordWidth-1:0] ir;
	logic [WordWidth-1:0] mdrReg;
	logic [WordWidth-1:0] mdrValue;
	logic [WordWidth-1:0] immExt;
	logic [MemAddrWidth-1:0] mar;
	logic mdrFromMem;
	logic conNext;

	programCounter programCounter_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Inc(Ctrl.pcInc),
		.Load(Ctrl.pcIn),
		.Bus(bus),
		.Pc(pc)
	);

	registerFile registerFile_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Ir(ir),
		.Gra(Ctrl.gra),
		.Grb(Ctrl.grb),
		.Grc(Ctrl.grc),
		.RIn(Ctrl.rIn),
		.ROut(Ctrl.rOut),
		.BaOut(Ctrl.baOut),
		.Bus(bus),
		.RegOut(regOut)
	);

	alu alu_inst (
		.Op(Ctrl.aluOp),
		.A(y),
		.B(bus),
		.Result(aluResult)
	);

	assign immExt = {{(WordWidth-19){ir[18]}}, ir[18:0]};

	// memory read data is registered in the memory itself, so MDR picks its last source
	assign mdrValue = mdrFromMem ? MemData : mdrReg;

	always_comb begin
		case (Ctrl.busSrc)
			busPc: bus = pc;
			busZLow: bus = z;
			busMdr: bus = mdrValue;
			busImm: bus = immExt;
			default: bus = regOut;
		endcase
	end

	always_comb begin
		case (ir[20:19])
			2'd0: conNext = (bus == '0);
			2'd1: conNext = (bus != '0);
			2'd2: conNext = !bus[WordWidth-1] && (bus != '0); // strictly positive
			default: conNext = bus[WordWidth-1];
		endcase
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			y <= '0;
			z <= '0;
			ir <= '0;
			mar <= '0;
			mdrReg <= '0;
			mdrFromMem <= 1'b0;
			Con <= 1'b0;
		end else begin
			if (Ctrl.yIn)
				y <= bus;
			if (Ctrl.zIn)
				z <= aluResult;
			if (Ctrl.irIn)
				ir <= bus;
			if (Ctrl.marIn)
				mar <= bus[MemAddrWidth-1:0];
			if (Ctrl.mdrIn)
				mdrReg <= bus;
			if (Ctrl.memRead)
				mdrFromMem <= 1'b1;
			else if (Ctrl.mdrIn)
				mdrFromMem <= 1'b0;
			if (Ctrl.conIn)
				Con <= conNext;
		end
	end

	assign MemAddress = mar;
	assign StoreData = Ctrl.mdrIn ? bus : mdrValue; // st6 writes the bus value through
	// during fetch2 report the word entering IR
	assign Opcode = opcodeT'(Ctrl.irIn ? bus[31:27] : ir[31:27]);

endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
	input logic Clock,
	input logic Reset,
	input cpuPkg::opcodeT Opcode,
	input logic Con,
	output cpuPkg::ctrlT Ctrl,
	output logic Halted
);
	import cpuPkg::*;

	stateT state;
	stateT stateNext;

	function automatic aluOpT opToAlu(opcodeT op);
		case (op)
			opAdd, opAddi: return aluAdd;
			opSub: return aluSub;
			opAnd, opAndi: return aluAnd;
			opOr, opOri: return aluOr;
			opShl: return aluShl;
			opShr: return aluShr;
			opNeg: return aluNeg;
			opNot: return aluNot;
			default: return aluIncPass;
		endcase
	endfunction

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			state <= stReset;
		else
			state <= stateNext;
	end

	always_comb begin
		stateNext = stFetch0; // most sequences fall back to fetch
		case (state)
			stFetch0: stateNext = stFetch1;
			stFetch1: stateNext = stFetch2;
			stFetch2: begin
				case (Opcode) // opcode of the word going into IR
					opAdd, opSub, opAnd, opOr, opShl, opShr: stateNext = stAlu3;
					opAddi, opAndi, opOri: stateNext = stImm3;
					opNeg, opNot: stateNext = stUn3;
					opLd: stateNext = stLd3;
					opLdi: stateNext = stLdi3;
					opSt: stateNext = stSt3;
					opBr: stateNext = stBr3;
					opHalt: stateNext = stHalt;
					default: stateNext = stNop3;
				endcase
			end
			stAlu3: stateNext = stAlu4;
			stAlu4: stateNext = stAlu5;
			stImm3: stateNext = stImm4;
			stImm4: stateNext = stImm5;
			stUn3: stateNext = stUn4;
			stLd3: stateNext = stLd4;
			stLd4: stateNext = stLd5;
			stLd5: stateNext = stLd6;
			stLd6: stateNext = stLd7;
			stLdi3: stateNext = stLdi4;
			stLdi4: stateNext = stLdi5;
			stSt3: stateNext = stSt4;
			stSt4: stateNext = stSt5;
			stSt5: stateNext = stSt6;
			stBr3: stateNext = stBr4;
			stBr4: stateNext = stBr5;
			stBr5: stateNext = stBr6;
			stHalt: stateNext = stHalt;
			default: stateNext = stFetch0;
		endcase
	end

	always_comb begin
		Ctrl = '0;
		case (state)
			stFetch0: begin
				Ctrl.busSrc = busPc;
				Ctrl.marIn = 1'b1;
				Ctrl.pcInc = 1'b1;
			end
			stFetch1, stLd6: Ctrl.memRead = 1'b1;
			stFetch2: begin
				Ctrl.busSrc = busMdr;
				Ctrl.irIn = 1'b1;
			end
			stAlu3, stImm3: begin
				Ctrl.grb = 1'b1;
				Ctrl.rOut = 1'b1;
				Ctrl.yIn = 1'b1;
			end
			stLd3, stLdi3, stSt3: begin // base with r0 read as zero
				Ctrl.grb = 1'b1;
				Ctrl.baOut = 1'b1;
				Ctrl.yIn = 1'b1;
			end
			stAlu4: begin
				Ctrl.grc = 1'b1;
				Ctrl.rOut = 1'b1;
				Ctrl.aluOp = opToAlu(Opcode);
				Ctrl.zIn = 1'b1;
			end
			stUn3: begin
				Ctrl.grb = 1'b1;
				Ctrl.rOut = 1'b1;
				Ctrl.aluOp = opToAlu(Opcode);
				Ctrl.zIn = 1'b1;
			end
			stImm4: begin
				Ctrl.busSrc = busImm;
				Ctrl.aluOp = opToAlu(Opcode);
				Ctrl.zIn = 1'b1;
			end
			stLd4, stLdi4, stSt4, stBr5: begin
				Ctrl.busSrc = busImm;
				Ctrl.aluOp = aluIncPass;
				Ctrl.zIn = 1'b1;
			end
			stAlu5, stImm5, stUn4, stLdi5: begin
				Ctrl.busSrc = busZLow;
				Ctrl.gra = 1'b1;
				Ctrl.rIn = 1'b1;
			end
			stLd5, stSt5: begin
				Ctrl.busSrc = busZLow;
				Ctrl.marIn = 1'b1;
			end
			stLd7: begin
				Ctrl.busSrc = busMdr;
				Ctrl.gra = 1'b1;
				Ctrl.rIn = 1'b1;
			end
			stSt6: begin
				Ctrl.gra = 1'b1;
				Ctrl.rOut = 1'b1;
				Ctrl.mdrIn = 1'b1;
				Ctrl.memWrite = 1'b1;
			end
			stBr3: begin
				Ctrl.gra = 1'b1;
				Ctrl.rOut = 1'b1;
				Ctrl.conIn = 1'b1;
			end
			stBr4: begin
				Ctrl.busSrc = busPc;
				Ctrl.yIn = 1'b1;
			end
			stBr6: begin
				Ctrl.busSrc = busZLow;
				Ctrl.pcIn = Con; // taken branch only
			end
			default: Ctrl = '0;
		endcase
	end

	assign Halted = (state == stHalt);

endmodule

// ==== hw/cpuTop.sv ====
`timescale 1ns/10ps

module cpuTop #(
	parameter int MemAddrWidth = 9
) (
	input logic Clock,
	input logic Reset,
	input logic LoadWrite,
	input logic [MemAddrWidth-1:0] LoadAddress,
	input logic [cpuPkg::WordWidth-1:0] LoadData,
	output logic [cpuPkg::WordWidth-1:0] ProbeData,
	output logic Halted
);
	import cpuPkg::*;

	ctrlT ctrl;
	opcodeT opcode;
	logic con;
	logic [MemAddrWidth-1:0] memAddress;
	logic [WordWidth-1:0] storeData;
	logic [WordWidth-1:0] memData;

	controlUnit controlUnit_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Opcode(opcode),
		.Con(con),
		.Ctrl(ctrl),
		.Halted(Halted)
	);

	dataPath #(
		.MemAddrWidth(MemAddrWidth)
	) dataPath_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Ctrl(ctrl),
		.MemData(memData),
		.MemAddress(memAddress),
		.StoreData(storeData),
		.Opcode(opcode),
		.Con(con)
	);

	dataMemory #(
		.MemAddrWidth(MemAddrWidth)
	) dataMemory_inst (
		.Clock(Clock),
		.Read(ctrl.memRead),
		.Write(ctrl.memWrite),
		.Address(memAddress),
		.WriteData(storeData),
		.ReadData(memData),
		.LoadWrite(LoadWrite),
		.LoadAddress(LoadAddress),
		.LoadData(LoadData),
		.ProbeData(ProbeData)
	);

endmodule

// ==== verif/clockGen.sv ====
`timescale 1ns/10ps

module clockGen #(
	parameter int Period = 20
) (
	input logic Hold,
	output logic Clock,
	output logic Reset
);

	logic powerOn;

	initial begin
		Clock = 1'b0;
		forever #(Period / 2) Clock = ~Clock;
	end

	initial begin
		powerOn <= 1'b1;
		repeat (2) @(posedge Clock);
		powerOn <= 1'b0;
	end

	assign Reset = powerOn || Hold; // held longer while memory is loaded

endmodule

// ==== verif/controlUnit_checker.sv ====
`timescale 1ns/10ps

module controlUnit_checker (
	input logic Clock,
	input logic Reset,
	input cpuPkg::ctrlT Ctrl,
	input logic Halted
);
	import cpuPkg::*;

	int failCount = 0;

	// register file may only drive when it is the selected source
	assert property (@(posedge Clock) disable iff (Reset)
		(Ctrl.rOut || Ctrl.baOut) |-> (Ctrl.busSrc == busReg && !(Ctrl.rOut && Ctrl.baOut)))
	else begin
		failCount++;
		$error("register file enabled onto the bus together with another source");
	end

	assert property (@(posedge Clock) disable iff (Reset)
		$countones({Ctrl.gra, Ctrl.grb, Ctrl.grc}) <= 1)
	else begin
		failCount++;
		$error("more than one register field selected");
	end

	assert property (@(posedge Clock) disable iff (Reset) !(Ctrl.memRead && Ctrl.memWrite))
	else begin
		failCount++;
		$error("memory read and write in the same step");
	end

	assert property (@(posedge Clock) disable iff (Reset) Halted |=> Halted)
	else begin
		failCount++;
		$error("Halted dropped without a reset");
	end

endmodule

// ==== verif/cpuTb.sv ====
`timescale 1ns/10ps

module cpuTb;
	import cpuPkg::*;

	localparam int AddrWidth = 9;
	localparam int MemWords = 2 ** AddrWidth;
	localparam int ClockPeriod = 20;
	localparam int NumTests = 5;
	localparam int MaxProgram = 40;
	localparam int WindowBase = 256; // data region based at r8
	localparam int WindowWords = 64;
	// 50 instructions at 8 cycles, plus load and probe traffic of one run
	localparam int RunCycles = 50 * 8 + MaxProgram + 3 * WindowWords + 40;
	localparam int WatchdogTime = (NumTests + 1) * RunCycles * ClockPeriod;
	localparam logic [31:0] Seed = 32'hef45_b5a6;

	logic clock;
	logic reset;
	logic holdReset;
	logic loadWrite;
	logic [AddrWidth-1:0] loadAddress;
	logic [31:0] loadData;
	logic [31:0] probeData;
	logic halted;

	logic [31:0] image [MemWords];
	logic [31:0] modelMem [MemWords];
	logic [31:0] modelReg [16];
	int progLen;
	int slot;
	int kind;
	int errorCount;
	int testErrors;
	int failedTests;
	opcodeT regOps [6] = '{opAdd, opSub, opAnd, opOr, opNeg, opNot};
	opcodeT immOps [5] = '{opShl, opShr, opAddi, opAndi, opOri};
	string testNames [NumTests] = '{"register ops", "shifts and immediates",
		"memory traffic", "branches", "halt and reset"};

	clockGen #(.Period(ClockPeriod)) clockGen_inst (
		.Hold(holdReset),
		.Clock(clock),
		.Reset(reset)
	);

	cpuTop #(.MemAddrWidth(AddrWidth)) cpuTop_inst (
		.Clock(clock),
		.Reset(reset),
		.LoadWrite(loadWrite),
		.LoadAddress(loadAddress),
		.LoadData(loadData),
		.ProbeData(probeData),
		.Halted(halted)
	);

	bind controlUnit controlUnit_checker controlUnit_checker_inst (
		.Clock(Clock),
		.Reset(Reset),
		.Ctrl(Ctrl),
		.Halted(Halted)
	);

	function automatic logic [31:0] encode(opcodeT op, logic [3:0] ra, logic [3:0] rb,
			logic [18:0] low);
		return {op, ra, rb, low};
	endfunction

	function automatic logic [31:0] fillWord(int addr);
		return (32'(addr) + 32'd1) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
	endfunction

	function automatic logic [3:0] pickReg(int lo, int hi);
		return 4'($urandom_range(hi, lo));
	endfunction

	task automatic compareWord(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected) begin
			errorCount++;
			testErrors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic emit(logic [31:0] word);
		image[progLen] = word;
		progLen++;
	endtask

	// ld or st at a window offset from r0 or r8
	task automatic memRef(opcodeT op, logic [3:0] r, int offset);
		if ($urandom_range(1, 0) == 0)
			emit(encode(op, r, 4'd0, 19'(WindowBase + offset)));
		else
			emit(encode(op, r, 4'd8, 19'(offset)));
	endtask

	task automatic buildProgram(int sel);
		int len;
		int pick;
		int offset;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [31:0] value;
		opcodeT op;
		len = $urandom_range(MaxProgram, 20);
		progLen = 0;
		slot = 0;
		for (int a = 0; a < MemWords; a++)
			image[a] = fillWord(a);
		for (int r = 1; r <= 4; r++)
			emit(encode(opLdi, 4'(r), 4'd0, 19'($urandom)));
		emit(encode(opLdi, 4'd8, 4'd0, 19'(WindowBase)));
		while (progLen + 3 < len) begin
			ra = pickReg(1, 7);
			case (sel)
				0: begin
					pick = $urandom_range(5, 0);
					emit(encode(regOps[pick], ra, pickReg(0, 7), {pickReg(0, 7), 15'd0}));
					memRef(opSt, ra, slot);
					slot++;
				end
				1: begin
					pick = $urandom_range(4, 0);
					op = immOps[pick];
					if (op == opShl || op == opShr)
						emit(encode(op, ra, pickReg(1, 7), {pickReg(1, 7), 15'd0}));
					else
						emit(encode(op, ra, pickReg(1, 7), 19'($urandom))); // either sign
					memRef(opSt, ra, slot);
					slot++;
				end
				2: begin
					rb = pickReg(1, 7);
					memRef(opSt, rb, slot);
					// mostly the word just stored, sometimes any window word
					if ($urandom_range(3, 0) == 0)
						offset = $urandom_range(WindowWords - 1, 0);
					else
						offset = slot;
					memRef(opLd, ra, offset);
					memRef(opSt, ra, slot + 1);
					slot += 2;
				end
				default: begin
					case ($urandom_range(3, 0))
						0: value = 32'd0;
						1: value = 32'($urandom_range(1000, 1));
						2: value = 32'd0 - 32'($urandom_range(1000, 1));
						default: value = $urandom;
					endcase
					emit(encode(opLdi, ra, 4'd0, 19'(value)));
					emit(encode(opBr, ra, 4'($urandom_range(3, 0)), 19'd1)); // hop the store
					memRef(opSt, pickReg(1, 7), slot);
					slot++;
				end
			endcase
		end
		while (progLen < len - 1)
			emit(encode(opNop, 4'd0, 4'd0, 19'd0));
		emit(encode(opHalt, 4'd0, 4'd0, 19'd0));
	endtask

	task automatic runModel();
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [3:0] ra;
		logic taken;
		logic done;
		int steps;
		pc = 32'd0;
		done = 1'b0;
		steps = 0;
		for (int a = 0; a < MemWords; a++)
			modelMem[a] = image[a];
		for (int r = 0; r < 16; r++)
			modelReg[r] = 32'd0;
		while (!done && steps < 1000) begin
			ins = modelMem[pc[AddrWidth-1:0]];
			pc = pc + 32'd1;
			steps++;
			ra = ins[26:23];
			b = modelReg[ins[22:19]];
			c = modelReg[ins[18:15]];
			imm = {{13{ins[18]}}, ins[18:0]};
			addr = ((ins[22:19] == 4'd0) ? 32'd0 : b) + imm; // r0 base is zero
			case (ins[31:27])
				opAdd: modelReg[ra] = b + c;
				opSub: modelReg[ra] = b - c;
				opAnd: modelReg[ra] = b & c;
				opOr: modelReg[ra] = b | c;
				opShl: modelReg[ra] = b << c[4:0];
				opShr: modelReg[ra] = b >> c[4:0];
				opAddi: modelReg[ra] = b + imm;
				opAndi: modelReg[ra] = b & imm;
				opOri: modelReg[ra] = b | imm;
				opNeg: modelReg[ra] = 32'd0 - b;
				opNot: modelReg[ra] = ~b;
				opLd: modelReg[ra] = modelMem[addr[AddrWidth-1:0]];
				opLdi: modelReg[ra] = addr;
				opSt: modelMem[addr[AddrWidth-1:0]] = modelReg[ra];
				opBr: begin
					c = modelReg[ra];
					case (ins[20:19])
						2'd0: taken = (c == 32'd0);
						2'd1: taken = (c != 32'd0);
						2'd2: taken = !c[31] && (c != 32'd0);
						default: taken = c[31];
					endcase
					if (taken)
						pc = pc + imm; // pc already points past the branch
				end
				opHalt: done = 1'b1;
				default: ;
			endcase
		end
		if (!done) begin
			errorCount++;
			testErrors++;
			$display("model ran %0d steps without reaching halt", steps);
		end
	endtask

	// load under reset, release, wait for halt
	task automatic runProgram();
		int addr;
		@(posedge clock);
		holdReset <= 1'b1;
		repeat (2) @(posedge clock);
		for (int i = 0; i < progLen + WindowWords; i++) begin
			addr = (i < progLen) ? i : WindowBase + i - progLen;
			loadWrite <= 1'b1;
			loadAddress <= AddrWidth'(addr);
			loadData <= image[addr];
			@(posedge clock);
		end
		loadWrite <= 1'b0;
		holdReset <= 1'b0;
		do
			@(negedge clock);
		while (!halted);
	endtask

	task automatic checkWindow();
		for (int i = 0; i < WindowWords; i++) begin
			@(posedge clock);
			loadAddress <= AddrWidth'(WindowBase + i);
			@(negedge clock);
			compareWord($sformatf("mem[%0d]", WindowBase + i), probeData,
				modelMem[WindowBase + i]);
		end
	endtask

	task automatic checkHaltAndRerun();
		repeat (20) begin
			@(negedge clock);
			compareWord("Halted", 32'(halted), 32'd1);
		end
		checkWindow(); // nothing written while halted
		@(posedge clock);
		holdReset <= 1'b1;
		@(negedge clock);
		compareWord("Halted", 32'(halted), 32'd0);
		runProgram();
		checkWindow();
	endtask

	initial begin
		void'($urandom(Seed));
		holdReset <= 1'b1;
		loadWrite <= 1'b0;
		loadAddress <= '0;
		loadData <= '0;
		errorCount = 0;
		failedTests = 0;
		for (int t = 0; t < NumTests; t++) begin
			testErrors = 0;
			kind = (t < 4) ? t : int'($urandom_range(3, 0));
			buildProgram(kind);
			runModel();
			runProgram();
			checkWindow();
			if (t == NumTests - 1)
				checkHaltAndRerun();
			if (testErrors != 0)
				failedTests++;
			$display("test %0d %s: %0d instructions, %0d errors, %s", t, testNames[t], progLen,
				testErrors, (testErrors == 0) ? "ok" : "failed");
		end
		if (cpuTop_inst.controlUnit_inst.controlUnit_checker_inst.failCount != 0) begin
			$display("control checker assertions failed %0d times",
				cpuTop_inst.controlUnit_inst.controlUnit_checker_inst.failCount);
			errorCount += cpuTop_inst.controlUnit_inst.controlUnit_checker_inst.failCount;
		end
		$display("%0d tests, %0d failed, %0d errors", NumTests, failedTests, errorCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		#(WatchdogTime);
		$display("watchdog expired at %0t, Halted never rose", $time);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
hw/cpuPkg.sv
hw/programCounter.sv
hw/registerFile.sv
hw/alu.sv
hw/dataMemory.sv
hw/dataPath.sv
hw/controlUnit.sv
hw/cpuTop.sv
verif/clockGen.sv
verif/controlUnit_checker.sv
verif/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# a run that stops early counts as a failure too
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TESTS FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
